// File: verilog/scandoubler_pkg.sv
`default_nettype none

package scandoubler_pkg;

   ////////////////////
   // Line buffer sizing
   ////////////////////

   // 896 pixels per PAL line at 14 MHz
   localparam int LINE_ADDR_W = 10;

   ////////////////////
   // Pixel format
   ////////////////////

   // RGB 3:3:3 as produced by the machine core
   typedef struct packed {
      logic [2:0] r;
      logic [2:0] g;
      logic [2:0] b;
   } rgb333_t;

   ////////////////////
   // VGA line timer FSM
   ////////////////////

   typedef enum logic [1:0] {
      ts_idle        = 2'd0,
      ts_first_pass  = 2'd1,
      ts_second_pass = 2'd2
   } timer_state_t;

endpackage

`default_nettype wire

// File: verilog/line_if.sv
`default_nettype none

// Buffer writes and line events from PAL capture
interface line_if import scandoubler_pkg::*; #(
   parameter int addr_w = LINE_ADDR_W
) ();

   logic              wr_en;
   logic [addr_w-1:0] wr_addr;
   rgb333_t           wr_data;
   // Bank currently being filled
   logic              wr_bank;
   // Pixel count of the line just finished
   logic [addr_w-1:0] line_len;
   logic              line_start;

   modport capture (
      output wr_en, wr_addr, wr_data, wr_bank, line_len, line_start
   );

   modport mixer (
      input wr_en, wr_addr, wr_data, wr_bank
   );

   // Timer needs the bank to read from the other one
   modport timer (
      input line_start, line_len, wr_bank
   );

endinterface

`default_nettype wire

// File: verilog/scan_if.sv
`default_nettype none

// Read position and VGA timing from line timer
interface scan_if import scandoubler_pkg::*; #(
   parameter int addr_w = LINE_ADDR_W
) ();

   logic [addr_w-1:0] rd_addr;
   logic              rd_bank;
   // High while a buffered pixel is replayed
   logic              active;
   logic              second_pass;
   // Active low
   logic              hsync_vga;

   modport timer (
      output rd_addr, rd_bank, active, second_pass, hsync_vga
   );

   modport mixer (
      input rd_addr, rd_bank, active, second_pass, hsync_vga
   );

endinterface

`default_nettype wire

// File: verilog/pal_line_capture.sv
`default_nettype none

module pal_line_capture import scandoubler_pkg::*; #(
   parameter int addr_w = LINE_ADDR_W
) (
   input  logic    clk,
   input  logic    reset,
   input  logic    video_ce,
   input  rgb333_t pixel,
   input  logic    hsync_ext_n,
   line_if.capture lines
);

   logic              hsync_q;
   logic              hsync_fall;
   // Edge seen between two pixel strobes
   logic              edge_pend;
   logic              line_new;
   logic [addr_w-1:0] pix_cnt;

   ////////////////////
   // Sync edge detect
   ////////////////////

   assign hsync_fall = hsync_q & ~hsync_ext_n;
   assign line_new   = video_ce & (hsync_fall | edge_pend);

   always_ff @(posedge clk) begin
      if (reset) begin
         hsync_q   <= 1'b1;
         edge_pend <= 1'b0;
      end else begin
         hsync_q <= hsync_ext_n;
         // Hold an off-strobe edge until next pixel
         if (video_ce)
            edge_pend <= 1'b0;
         else if (hsync_fall)
            edge_pend <= 1'b1;
      end
   end

   ////////////////////
   // Pixel counter and banks
   ////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         lines.line_start <= 1'b0;
         lines.wr_en      <= 1'b0;
         lines.wr_bank    <= 1'b0;
         pix_cnt          <= '0;
      end else begin
         lines.line_start <= 1'b0;
         lines.wr_en      <= 1'b0;
         if (line_new) begin
            // New line, swap banks and restart count
            lines.line_start <= 1'b1;
            lines.wr_bank    <= ~lines.wr_bank;
            pix_cnt          <= '0;
         end else if (video_ce) begin
            lines.wr_en <= 1'b1;
            // Saturate at top address
            if (pix_cnt != '1)
               pix_cnt <= pix_cnt + 1'b1;
         end
      end
   end

   // Write payload and finished line length
   always_ff @(posedge clk) begin
      if (line_new) begin
         lines.line_len <= pix_cnt;
      end else if (video_ce) begin
         lines.wr_addr <= pix_cnt;
         lines.wr_data <= pixel;
      end
   end

endmodule

`default_nettype wire

// File: verilog/vga_line_timer.sv
`default_nettype none

module vga_line_timer import scandoubler_pkg::*; #(
   parameter int addr_w    = LINE_ADDR_W,
   parameter int hsync_len = 54
) (
   input  logic  clk,
   input  logic  reset,
   line_if.timer lines,
   scan_if.timer scan
);

   timer_state_t      state;
   logic [addr_w-1:0] rd_addr;
   // Length of the line being replayed
   logic [addr_w-1:0] len_q;
   logic              last_pixel;
   logic              in_sync;

   assign last_pixel = (rd_addr == len_q - 1'b1);

   ////////////////////
   // Replay FSM
   ////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state        <= ts_idle;
         rd_addr      <= '0;
         len_q        <= '0;
         scan.rd_bank <= 1'b0;
      end else if (lines.line_start) begin
         // New PAL line restarts replay from pixel 0
         state        <= (lines.line_len == '0) ? ts_idle : ts_first_pass;
         rd_addr      <= '0;
         len_q        <= lines.line_len;
         // Bank just toggled, so read the one just filled
         scan.rd_bank <= ~lines.wr_bank;
      end else begin
         unique case (state)
            ts_first_pass: begin
               if (last_pixel) begin
                  state   <= ts_second_pass;
                  rd_addr <= '0;
               end else begin
                  rd_addr <= rd_addr + 1'b1;
               end
            end
            ts_second_pass: begin
               if (last_pixel) begin
                  state   <= ts_idle;
                  rd_addr <= '0;
               end else begin
                  rd_addr <= rd_addr + 1'b1;
               end
            end
            default: begin
               // Idle until the next line start
               state   <= ts_idle;
               rd_addr <= '0;
            end
         endcase
      end
   end

   ////////////////////
   // Outputs to mixer
   ////////////////////

   // Sync pulse at the start of each pass
   assign in_sync = (state != ts_idle) && (rd_addr < addr_w'(hsync_len));

   assign scan.rd_addr     = rd_addr;
   assign scan.active      = (state != ts_idle);
   assign scan.second_pass = (state == ts_second_pass);
   assign scan.hsync_vga   = ~in_sync;

endmodule

`default_nettype wire

// File: verilog/vga_pixel_mixer.sv
`default_nettype none

module vga_pixel_mixer import scandoubler_pkg::*; #(
   parameter int addr_w = LINE_ADDR_W
) (
   input  logic    clk,
   input  logic    reset,
   line_if.mixer   lines,
   scan_if.mixer   scan,
   input  logic    enable_scandoubling,
   input  logic    disable_scaneffect,
   input  rgb333_t pixel_in,
   input  logic    hsync_ext_n,
   input  logic    vsync_ext_n,
   output rgb333_t pixel_out,
   output logic    hsync,
   output logic    vsync
);

   // Two banks of one line each, bank is the top address bit
   rgb333_t line_mem [2**(addr_w+1)];
   rgb333_t rd_data;

   // Timer flags delayed to match the read data
   logic    active_d;
   logic    second_d;
   logic    hsync_vga_d;
   rgb333_t scan_pixel;

   ////////////////////
   // Line buffer
   ////////////////////

   always_ff @(posedge clk) begin
      if (lines.wr_en)
         line_mem[{lines.wr_bank, lines.wr_addr}] <= lines.wr_data;
   end

   // Synchronous read, one cycle latency
   always_ff @(posedge clk) begin
      rd_data <= line_mem[{scan.rd_bank, scan.rd_addr}];
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         active_d    <= 1'b0;
         second_d    <= 1'b0;
         hsync_vga_d <= 1'b1;
      end else begin
         active_d    <= scan.active;
         second_d    <= scan.second_pass;
         hsync_vga_d <= scan.hsync_vga;
      end
   end

   ////////////////////
   // Scanline effect
   ////////////////////

   always_comb begin
      scan_pixel = rd_data;
      // Darker second pass, each field halved
      if (second_d && !disable_scaneffect) begin
         scan_pixel.r = {1'b0, rd_data.r[2:1]};
         scan_pixel.g = {1'b0, rd_data.g[2:1]};
         scan_pixel.b = {1'b0, rd_data.b[2:1]};
      end
      // Blank outside replay
      if (!active_d)
         scan_pixel = '0;
   end

   ////////////////////
   // Output register
   ////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         pixel_out <= '0;
         hsync     <= 1'b1;
         vsync     <= 1'b1;
      end else begin
         vsync <= vsync_ext_n;
         if (enable_scandoubling) begin
            pixel_out <= scan_pixel;
            hsync     <= hsync_vga_d;
         end else begin
            // Passthrough of the 15 kHz picture
            pixel_out <= pixel_in;
            hsync     <= hsync_ext_n;
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/vga_scandoubler.sv
`default_nettype none

module vga_scandoubler import scandoubler_pkg::*; #(
   parameter int addr_w    = LINE_ADDR_W,
   parameter int hsync_len = 54
) (
   input  wire       clk,
   input  wire       reset,
   input  wire       video_ce,
   input  wire [2:0] ri,
   input  wire [2:0] gi,
   input  wire [2:0] bi,
   input  wire       hsync_ext_n,
   input  wire       vsync_ext_n,
   input  wire       enable_scandoubling,
   input  wire       disable_scaneffect,
   output wire [2:0] ro,
   output wire [2:0] go,
   output wire [2:0] bo,
   output wire       hsync,
   output wire       vsync
);

   rgb333_t pixel_in;
   rgb333_t pixel_out;

   // Pack core colour into one pixel
   assign pixel_in = '{r: ri, g: gi, b: bi};

   line_if #(.addr_w(addr_w)) lines ();
   scan_if #(.addr_w(addr_w)) scan ();

   ////////////////////
   // PAL side
   ////////////////////

   pal_line_capture #(.addr_w(addr_w)) capture (
      .clk         (clk),
      .reset       (reset),
      .video_ce    (video_ce),
      .pixel       (pixel_in),
      .hsync_ext_n (hsync_ext_n),
      .lines       (lines.capture)
   );

   ////////////////////
   // VGA side
   ////////////////////

   vga_line_timer #(
      .addr_w    (addr_w),
      .hsync_len (hsync_len)
   ) timer (
      .clk   (clk),
      .reset (reset),
      .lines (lines.timer),
      .scan  (scan.timer)
   );

   vga_pixel_mixer #(.addr_w(addr_w)) mixer (
      .clk                 (clk),
      .reset               (reset),
      .lines               (lines.mixer),
      .scan                (scan.mixer),
      .enable_scandoubling (enable_scandoubling),
      .disable_scaneffect  (disable_scaneffect),
      .pixel_in            (pixel_in),
      .hsync_ext_n         (hsync_ext_n),
      .vsync_ext_n         (vsync_ext_n),
      .pixel_out           (pixel_out),
      .hsync               (hsync),
      .vsync               (vsync)
   );

   // Unpack to monitor pins
   assign ro = pixel_out.r;
   assign go = pixel_out.g;
   assign bo = pixel_out.b;

endmodule

`default_nettype wire

// File: sim/vga_scandoubler_assert.sv
`default_nettype none

module vga_scandoubler_assert import scandoubler_pkg::*; #(
   parameter int hsync_len = 54
) (
   input wire          clk,
   input wire          reset,
   input wire          enable_scandoubling,
   input wire  [2:0]   ri,
   input wire  [2:0]   gi,
   input wire  [2:0]   bi,
   input wire          hsync_ext_n,
   input wire          vsync_ext_n,
   input wire  [2:0]   ro,
   input wire  [2:0]   go,
   input wire  [2:0]   bo,
   input wire          hsync,
   input wire          vsync,
   input wire          line_start,
   input timer_state_t timer_state
);

   timeunit 1ns;
   timeprecision 100ps;

   // Length of the current low run on hsync
   int low_run;

   always_ff @(posedge clk) begin
      if (reset || hsync)
         low_run <= 0;
      else
         low_run <= low_run + 1;
   end

   ////////////////////
   // Both modes
   ////////////////////

   // Vertical sync is one register late
   vsync_delay: assert property (@(posedge clk) disable iff (reset)
      !$past(reset) |-> vsync == $past(vsync_ext_n))
      else $error("vsync is not vsync_ext_n delayed by one cycle");

   // Passthrough, picture and sync one register late
   passthrough_delay: assert property (@(posedge clk) disable iff (reset)
      !$past(reset) && !$past(enable_scandoubling)
      |-> hsync == $past(hsync_ext_n) && {ro, go, bo} == $past({ri, gi, bi}))
      else $error("passthrough output is not the input delayed by one cycle");

   ////////////////////
   // Doubling mode
   ////////////////////

   // One cycle to first pass, two through the mixer
   first_pass_sync: assert property (@(posedge clk) disable iff (reset)
      $past(line_start, 3) && $past(enable_scandoubling) |-> !hsync)
      else $error("hsync not low three cycles after line start");

   // Second pass sync after the same mixer delay
   second_pass_sync: assert property (@(posedge clk) disable iff (reset)
      $past(timer_state, 3) == ts_first_pass && $past(timer_state, 2) == ts_second_pass
      && $past(enable_scandoubling) |-> !hsync)
      else $error("hsync not low at start of second pass");

   // Each VGA sync pulse is exactly hsync_len cycles
   sync_width: assert property (@(posedge clk) disable iff (reset)
      enable_scandoubling && $past(enable_scandoubling) && $rose(hsync)
      |-> low_run == hsync_len)
      else $error("VGA hsync pulse has the wrong length");

endmodule

bind vga_scandoubler vga_scandoubler_assert #(
   .hsync_len (hsync_len)
) timing_checks (
   .clk                 (clk),
   .reset               (reset),
   .enable_scandoubling (enable_scandoubling),
   .ri                  (ri),
   .gi                  (gi),
   .bi                  (bi),
   .hsync_ext_n         (hsync_ext_n),
   .vsync_ext_n         (vsync_ext_n),
   .ro                  (ro),
   .go                  (go),
   .bo                  (bo),
   .hsync               (hsync),
   .vsync               (vsync),
   .line_start          (lines.line_start),
   .timer_state         (timer.state)
);

`default_nettype wire

// File: sim/tb_vga_scandoubler.sv
`default_nettype none

module tb_vga_scandoubler import scandoubler_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   ////////////////////
   // Test sizing
   ////////////////////

   localparam int clk_period   = 40;
   localparam int reset_cycles = 16;
   // PAL line counted in pixel strobes
   localparam int line_pix     = 100;
   localparam int sync_pix     = 20;
   localparam int line_clks    = 2 * line_pix;
   // Sync edge strobe is not stored
   localparam int replay_len   = line_pix - 1;
   localparam int hsync_len    = 10;
   localparam int idle_clks    = 40;
   localparam int num_lines    = 16;
   // Whole run plus two lines of slack
   localparam int limit_clks   = reset_cycles + idle_clks + (num_lines + 2) * line_clks;

   logic       clk;
   logic       reset;
   logic       video_ce;
   logic [2:0] ri;
   logic [2:0] gi;
   logic [2:0] bi;
   logic       hsync_ext_n;
   logic       vsync_ext_n;
   logic       enable_scandoubling;
   logic       disable_scaneffect;
   wire  [2:0] ro;
   wire  [2:0] go;
   wire  [2:0] bo;
   wire        hsync;
   wire        vsync;

   logic [31:0] lfsr_state;

   // Current line and the two before it
   rgb333_t line_cur   [replay_len];
   rgb333_t line_prev  [replay_len];
   rgb333_t line_prev2 [replay_len];
   bit      cur_ok;
   bit      prev_ok;
   bit      prev2_ok;

   vga_scandoubler #(.hsync_len(hsync_len)) uut (
      .clk                 (clk),
      .reset               (reset),
      .video_ce            (video_ce),
      .ri                  (ri),
      .gi                  (gi),
      .bi                  (bi),
      .hsync_ext_n         (hsync_ext_n),
      .vsync_ext_n         (vsync_ext_n),
      .enable_scandoubling (enable_scandoubling),
      .disable_scaneffect  (disable_scaneffect),
      .ro                  (ro),
      .go                  (go),
      .bo                  (bo),
      .hsync               (hsync),
      .vsync               (vsync)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   ////////////////////
   // Helpers
   ////////////////////

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   // One LFSR step per pixel bit
   task automatic draw_pixel(output rgb333_t p);
      logic [8:0] bits;
      int         i;
      bits = '0;
      for (i = 0; i < 9; i++) begin
         bits       = {bits[7:0], lfsr_state[31]};
         lfsr_state = lfsr_step(lfsr_state);
      end
      p = bits;
   endtask

   // Scanline look drops the low bit of each field
   function automatic rgb333_t darken(input rgb333_t p);
      rgb333_t d;
      d.r = p.r >> 1;
      d.g = p.g >> 1;
      d.b = p.b >> 1;
      return d;
   endfunction

   task automatic report_mismatch(input string test, input int expected, input int actual);
      $display("ERR %s expected=%0h actual=%0h", test, expected, actual);
      $display("SIMULATION FAILED");
      $fatal(1, "output mismatch");
   endtask

   // Replay seen at clock t of a line lags the read by two cycles
   task automatic check_output(input int t);
      rgb333_t actual;
      rgb333_t expected;
      bit      known;
      bit      second;
      string   test;
      actual   = {ro, go, bo};
      expected = '0;
      known    = 1'b0;
      second   = 1'b0;
      test     = disable_scaneffect ? "line_double" : "scan_effect";
      if (t < 2) begin
         // Tail of the second pass started one line back
         known  = prev2_ok;
         second = 1'b1;
         if (known)
            expected = line_prev2[replay_len - 2 + t];
      end else if (t < 4) begin
         // Gap between replays
         known = prev_ok;
         test  = "replay_gap";
      end else if (t < 4 + replay_len) begin
         known = prev_ok;
         if (known)
            expected = line_prev[t - 4];
      end else begin
         known  = prev_ok;
         second = 1'b1;
         if (known)
            expected = line_prev[t - 4 - replay_len];
      end
      if (second && !disable_scaneffect)
         expected = darken(expected);
      if (known && actual !== expected)
         report_mismatch(test, expected, actual);
   endtask

   ////////////////////
   // Stimulus
   ////////////////////

   // Doubler on with strobes running and no sync edge
   task automatic run_idle();
      rgb333_t pix;
      int      t;
      for (t = 0; t < idle_clks; t++) begin
         @(negedge clk);
         if (hsync !== 1'b1)
            report_mismatch("reset_idle", 1, hsync);
         if (vsync !== 1'b1)
            report_mismatch("reset_idle", 1, vsync);
         if ({ro, go, bo} !== 9'd0)
            report_mismatch("reset_idle", 0, {ro, go, bo});
         video_ce = (t % 2 == 0);
         if (video_ce) begin
            draw_pixel(pix);
            {ri, gi, bi} = pix;
         end
      end
   endtask

   // One PAL line with its sync edge on the first strobe
   task automatic send_line(input bit doubling, input bit effect_off, input bit vsync_low);
      rgb333_t pix;
      int      t;
      int      strobe;
      line_prev2 = line_prev;
      prev2_ok   = prev_ok;
      line_prev  = line_cur;
      prev_ok    = cur_ok;
      cur_ok     = 1'b1;
      for (t = 0; t < line_clks; t++) begin
         @(negedge clk);
         // Outputs first as they belong to the last rising edge
         if (enable_scandoubling)
            check_output(t);
         strobe              = t / 2;
         video_ce            = (t % 2 == 0);
         hsync_ext_n         = (strobe >= sync_pix);
         vsync_ext_n         = !vsync_low;
         enable_scandoubling = doubling;
         disable_scaneffect  = effect_off;
         if (video_ce) begin
            draw_pixel(pix);
            {ri, gi, bi} = pix;
            // Strobe n lands at address n - 1
            if (strobe > 0)
               line_cur[strobe - 1] = pix;
         end
      end
   endtask

   ////////////////////
   // Test sequence
   ////////////////////

   initial begin
      int n;
      lfsr_state          = 32'h76127d34;
      reset               = 1'b1;
      video_ce            = 1'b0;
      ri                  = '0;
      gi                  = '0;
      bi                  = '0;
      hsync_ext_n         = 1'b1;
      vsync_ext_n         = 1'b1;
      enable_scandoubling = 1'b1;
      disable_scaneffect  = 1'b1;
      cur_ok              = 1'b0;
      prev_ok             = 1'b0;
      prev2_ok            = 1'b0;
      repeat (reset_cycles) @(negedge clk);
      reset = 1'b0;
      run_idle();
      // Passthrough then plain doubling then scanline effect
      for (n = 0; n < num_lines; n++)
         send_line((n >= 4) && (n <= 14), n < 9, (n == 2) || (n == 11));
      repeat (4) @(negedge clk);
      $display("SIMULATION PASSED");
      $finish;
   end

   // Watchdog
   initial begin
      #(limit_clks * clk_period);
      $display("watchdog expired before the line sequence finished");
      $display("SIMULATION FAILED");
      $fatal(1, "timeout");
   end

endmodule

`default_nettype wire

// File: compile.f
verilog/scandoubler_pkg.sv
verilog/line_if.sv
verilog/scan_if.sv
verilog/pal_line_capture.sv
verilog/vga_line_timer.sv
verilog/vga_pixel_mixer.sv
verilog/vga_scandoubler.sv
sim/vga_scandoubler_assert.sv
sim/tb_vga_scandoubler.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the scandoubler testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_vga_scandoubler -f compile.f \
   --Mdir obj_dir -o tb_vga_scandoubler
./obj_dir/tb_vga_scandoubler
